// File: mips_cpu_bus.f
+incdir+src
src/mips_pkg.sv
src/mips_sequencer.sv
src/mips_bus_unit.sv
src/mips_decoder.sv
src/mips_regfile.sv
src/mips_execute.sv
src/mips_cpu_bus.sv
sim/mem_model.sv
sim/tb_mips_cpu_bus.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f mips_cpu_bus.f \
  --top-module tb_mips_cpu_bus \
  -o tb_mips_cpu_bus

./obj_dir/tb_mips_cpu_bus > sim.log
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
  exit 1
fi

// File: sim/tb_mips_cpu_bus.sv
`timescale 1ns/100ps
`include "mips_config.svh"

module tb_mips_cpu_bus;

  localparam int MAX_CYCLES   = 4000;  // ~60 instructions at 4 phases plus waits and margin
  localparam int DRAIN_CYCLES = 40;    // quiet time watched after the halt

  logic                  clk, reset, active, read, write, waitrequest;
  logic [`MIPS_XLEN-1:0] register_v0, address, writedata, readdata;
  logic [3:0]            byteenable;

  int                    errors      = 0;
  int                    writes_seen = 0;
  int                    cycles;
  logic [`MIPS_XLEN-1:0] exp_addr, exp_store, exp_v0, final_v0;
  logic [`MIPS_XLEN-1:0] prev_addr   = '0;
  logic [`MIPS_XLEN-1:0] prev_wdata  = '0;
  logic                  prev_reset  = 1'b1;
  logic                  prev_req    = 1'b0;
  logic                  prev_wait   = 1'b0;
  logic                  prev_read   = 1'b0;
  logic                  prev_write  = 1'b0;
  logic                  seen_read   = 1'b0;
  logic                  halted      = 1'b0;

  mips_cpu_bus dut_i (
    .clk, .reset, .active, .register_v0, .address, .write, .read,
    .waitrequest, .writedata, .byteenable, .readdata
  );

  mem_model mem_i (
    .clk, .address, .read, .write, .writedata, .byteenable, .waitrequest, .readdata
  );

  task automatic log_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
    errors++;
    $display("ERR %0t %s expected %h actual %h", $time, name, exp, got);
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("%0t: %s", $time, what);
  endtask

  // expected results of the program in mips terms
  initial begin : model_program
    logic [31:0] t0, t1, t2, t3, v0, s0;
    t0 = 32'h0000_1234;
    t1 = 32'hABCD_0000;       // lui
    t1 = t1 | 32'h0000_5678;  // ori
    t2 = t0 + t1;
    t3 = 32'hFFFF_FFFD;       // addiu -3 sign extended
    t2 = t2 - t3;
    v0 = t2 & t1;
    t3 = ($signed(t1) < $signed(t0)) ? 32'd1 : 32'd0;
    v0 = v0 | t3;
    s0 = 32'h0000_4000;       // base of the data area
    exp_addr  = s0 + 32'd4;
    exp_store = v0;           // stored by sw and read back by lw
    v0 = v0 + exp_store;
    for (int n = 5; n != 0; n--)
      v0 = v0 + 32'd3;        // five bne passes while beq and j skip their adds
    exp_v0 = v0;
  end

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // bus and result checks at mid cycle where everything has settled
  always @(negedge clk) begin
    if (reset) begin
      assert (!read && !write) else note_failure("bus request raised during reset");
    end else begin
      if (prev_reset) begin
        assert (active) else note_failure("active low in the first cycle after reset");
      end
      if (read && !seen_read) begin
        seen_read = 1'b1;
        assert (address == `MIPS_RESET_VECTOR)
          else log_mismatch("address", `MIPS_RESET_VECTOR, address);
      end
      assert (!(read && write)) else note_failure("read and write high together");
      if (read || write) begin
        assert (address[1:0] == 2'b00)
          else log_mismatch("address", {address[31:2], 2'b00}, address);
        assert (byteenable == 4'hF) else log_mismatch("byteenable", 32'hF, {28'd0, byteenable});
      end
      if (prev_req && prev_wait) begin  // held transfer
        assert (address == prev_addr) else log_mismatch("address", prev_addr, address);
        assert (writedata == prev_wdata) else log_mismatch("writedata", prev_wdata, writedata);
        assert (read == prev_read && write == prev_write)
          else note_failure("read or write changed while waitrequest was high");
      end
      if (write && !waitrequest) begin
        writes_seen++;
        assert (address == exp_addr) else log_mismatch("address", exp_addr, address);
        assert (writedata == exp_store) else log_mismatch("writedata", exp_store, writedata);
      end
      if (!active && !halted) begin
        halted   = 1'b1;
        final_v0 = register_v0;
        assert (register_v0 == exp_v0) else log_mismatch("register_v0", exp_v0, register_v0);
        assert (mem_i.mem[exp_addr[14:2]] == exp_store)
          else log_mismatch("mem_i.mem", exp_store, mem_i.mem[exp_addr[14:2]]);
        assert (writes_seen == 1) else note_failure("the store did not appear once on the bus");
      end else if (halted) begin
        assert (!read && !write) else note_failure("bus access after the core halted");
        assert (register_v0 == final_v0) else log_mismatch("register_v0", final_v0, register_v0);
      end
    end
    prev_reset = reset;
    prev_req   = read || write;
    prev_wait  = waitrequest;
    prev_read  = read;
    prev_write = write;
    prev_addr  = address;
    prev_wdata = writedata;
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    cycles = 0;
    while (active && cycles < MAX_CYCLES) begin  // active drops at the halt
      @(negedge clk);
      cycles++;
    end
    if (active)
      $display("timeout: core still running after %0d cycles", MAX_CYCLES);
    else
      repeat (DRAIN_CYCLES) @(posedge clk);
    $display("errors: %0d", errors);
    if (errors == 0 && !active)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: sim/mem_model.sv
`timescale 1ns/100ps
`include "mips_config.svh"

module mem_model (
  input  logic                    clk,
  input  logic [`MIPS_XLEN-1:0]   address,
  input  logic                    read,
  input  logic                    write,
  input  logic [`MIPS_XLEN-1:0]   writedata,
  input  logic [`MIPS_XLEN/8-1:0] byteenable,
  output logic                    waitrequest,
  output logic [`MIPS_XLEN-1:0]   readdata
);

  // 32 KB image where the upper address bits alias and 0xbfc00000 lands on word 0
  logic [`MIPS_XLEN-1:0] mem [8192];
  logic [12:0]           widx;       // word index
  logic [`MIPS_XLEN-1:0] lane_mask;  // byteenable spread to bits
  logic [31:0]           roll;
  integer                seed;

  assign widx      = address[14:2];
  assign lane_mask = {{8{byteenable[3]}}, {8{byteenable[2]}},
                      {8{byteenable[1]}}, {8{byteenable[0]}}};
  assign readdata  = read ? mem[widx] : '0;  // valid in the completing cycle

  initial begin
    seed        = 32'h58da_e4d0;
    waitrequest = 1'b0;
    for (int a = 0; a < 8192; a++)
      mem[a[12:0]] = {19'h5_BAD5, a[12:0]};  // opcode 0x2d is unused and runs as a nop
    mem[0]  = 32'h2408_1234;  // addiu $t0, $zero, 0x1234
    mem[1]  = 32'h3C09_ABCD;  // lui   $t1, 0xabcd
    mem[2]  = 32'h3529_5678;  // ori   $t1, $t1, 0x5678
    mem[3]  = 32'h0109_5021;  // addu  $t2, $t0, $t1
    mem[4]  = 32'h240B_FFFD;  // addiu $t3, $zero, -3
    mem[5]  = 32'h014B_5023;  // subu  $t2, $t2, $t3
    mem[6]  = 32'h0149_1024;  // and   $v0, $t2, $t1
    mem[7]  = 32'h0128_582A;  // slt   $t3, $t1, $t0
    mem[8]  = 32'h004B_1025;  // or    $v0, $v0, $t3
    mem[9]  = 32'h2410_4000;  // addiu $s0, $zero, 0x4000   data area at word 0x1000
    mem[10] = 32'hAE02_0004;  // sw    $v0, 4($s0)
    mem[11] = 32'h8E08_0004;  // lw    $t0, 4($s0)
    mem[12] = 32'h0048_1021;  // addu  $v0, $v0, $t0
    mem[13] = 32'h2409_0005;  // addiu $t1, $zero, 5   loop count
    mem[14] = 32'h2442_0003;  // loop: addiu $v0, $v0, 3
    mem[15] = 32'h2529_FFFF;  // addiu $t1, $t1, -1
    mem[16] = 32'h1520_FFFD;  // bne   $t1, $zero, loop
    mem[17] = 32'h1000_0001;  // beq   $zero, $zero, +1
    mem[18] = 32'h2442_0100;  // addiu $v0, $v0, 0x100   skipped
    mem[19] = 32'h0BF0_0015;  // j     0xbfc00054
    mem[20] = 32'h2442_0200;  // addiu $v0, $v0, 0x200   skipped
    mem[21] = 32'h0000_0008;  // jr    $zero   halts the core
  end

  // roughly every other cycle stalls
  always @(posedge clk) begin
    roll = $random(seed);
    waitrequest <= roll[0];
  end

  always @(posedge clk) begin
    if (write && !waitrequest)
      mem[widx] <= (mem[widx] & ~lane_mask) | (writedata & lane_mask);
  end

endmodule

// File: src/mips_cpu_bus.sv
`timescale 1ns/100ps
`include "mips_config.svh"

module mips_cpu_bus (
  input  logic                  clk,
  input  logic                  reset,
  output logic                  active,
  output logic [`MIPS_XLEN-1:0] register_v0,

  // avalon master
  output logic [`MIPS_XLEN-1:0]   address,
  output logic                    write,
  output logic                    read,
  input  logic                    waitrequest,
  output logic [`MIPS_XLEN-1:0]   writedata,
  output logic [`MIPS_XLEN/8-1:0] byteenable,
  input  logic [`MIPS_XLEN-1:0]   readdata
);

  mips_pkg::cpu_state_t  state;
  mips_pkg::ctrl_t       ctrl;
  mips_pkg::bus_req_t    fetch_req, data_req;
  mips_pkg::instr_u      instr;
  mips_pkg::wb_t         wb;
  logic [`MIPS_XLEN-1:0] pc, rs_data, rt_data, load_data;
  logic                  bus_done, mem_phase;

  mips_sequencer seq_i (
    .clk, .reset, .pc, .ctrl, .bus_done,
    .state, .active, .fetch_req, .mem_phase
  );

  // shared port, data side wins
  mips_bus_unit bus_i (
    .clk, .reset, .fetch_req, .data_req,
    .address, .writedata, .read, .write, .byteenable,
    .waitrequest, .readdata, .bus_done, .instr, .load_data
  );

  mips_decoder dec_i (.instr, .ctrl);

  mips_regfile rf_i (
    .clk, .reset, .instr, .wb, .rs_data, .rt_data, .register_v0
  );

  mips_execute ex_i (
    .clk, .reset, .state, .instr, .ctrl, .rs_data, .rt_data, .load_data,
    .mem_phase, .pc, .data_req, .wb
  );

endmodule

// File: src/mips_execute.sv
`timescale 1ns/100ps
`include "mips_config.svh"

module mips_execute (
  input  logic                  clk,
  input  logic                  reset,
  input  mips_pkg::cpu_state_t  state,
  input  mips_pkg::instr_u      instr,
  input  mips_pkg::ctrl_t       ctrl,
  input  logic [`MIPS_XLEN-1:0] rs_data,
  input  logic [`MIPS_XLEN-1:0] rt_data,
  input  logic [`MIPS_XLEN-1:0] load_data,
  input  logic                  mem_phase,
  output logic [`MIPS_XLEN-1:0] pc,
  output mips_pkg::bus_req_t    data_req,
  output mips_pkg::wb_t         wb
);

  logic [`MIPS_XLEN-1:0] imm_sx, imm_ext, op_a, op_b, alu_res;
  logic [`MIPS_XLEN-1:0] pc_plus4, br_target, j_target, next_pc;
  logic                  taken;

  assign imm_sx  = {{16{instr.i.imm[15]}}, instr.i.imm};
  assign imm_ext = ctrl.upper_imm ? {instr.i.imm, 16'h0000} :
                   ctrl.zero_ext  ? {16'h0000, instr.i.imm} : imm_sx;

  assign op_a = ctrl.upper_imm ? '0 : rs_data;  // lui ignores rs
  assign op_b = ctrl.use_imm ? imm_ext : rt_data;

  always_comb begin
    case (ctrl.alu_op)
      mips_pkg::ALU_SUB: alu_res = op_a - op_b;
      mips_pkg::ALU_AND: alu_res = op_a & op_b;
      mips_pkg::ALU_OR:  alu_res = op_a | op_b;
      mips_pkg::ALU_SLT: alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
      default:           alu_res = op_a + op_b;  // add, also the lw/sw address
    endcase
  end

  // load/store request, only during MEM
  always_comb begin
    data_req.addr  = {alu_res[`MIPS_XLEN-1:2], 2'b00};
    data_req.wdata = rt_data;
    data_req.read  = mem_phase && ctrl.is_load;
    data_req.write = mem_phase && ctrl.is_store;
  end

  // next pc, no delay slot
  assign pc_plus4  = pc + 32'd4;
  assign br_target = pc_plus4 + {imm_sx[`MIPS_XLEN-3:0], 2'b00};
  assign j_target  = {pc_plus4[31:28], instr.i.rs, instr.i.rt, instr.i.imm, 2'b00};  // low 26 bits
  assign taken     = (ctrl.is_beq && (rs_data == rt_data)) ||
                     (ctrl.is_bne && (rs_data != rt_data));

  always_comb begin
    if (ctrl.is_jr)
      next_pc = rs_data;
    else if (ctrl.is_jump)
      next_pc = j_target;
    else if (taken)
      next_pc = br_target;
    else
      next_pc = pc_plus4;
  end

  always_ff @(posedge clk) begin
    if (reset)
      pc <= `MIPS_RESET_VECTOR;
    else if (state == mips_pkg::EXEC)
      pc <= next_pc;
  end

  // writeback, only in the exec cycle
  always_comb begin
    wb.we   = (state == mips_pkg::EXEC) && ctrl.reg_write;
    wb.idx  = ctrl.dest_is_rt ? instr.i.rt : instr.r.rd;
    wb.data = ctrl.is_load ? load_data : alu_res;
  end

endmodule

// File: src/mips_regfile.sv
`timescale 1ns/100ps
`include "mips_config.svh"

module mips_regfile (
  input  logic                  clk,
  input  logic                  reset,
  input  mips_pkg::instr_u      instr,
  input  mips_pkg::wb_t         wb,
  output logic [`MIPS_XLEN-1:0] rs_data,
  output logic [`MIPS_XLEN-1:0] rt_data,
  output logic [`MIPS_XLEN-1:0] register_v0
);

  logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `MIPS_NUM_REGS; i++)
        regs[i] <= '0;
    end else if (wb.we && (wb.idx != 5'd0)) begin
      regs[wb.idx] <= wb.data;  // r0 never written, stays zero
    end
  end

  // read ports straight from the instruction fields
  assign rs_data     = regs[instr.r.rs];
  assign rt_data     = regs[instr.r.rt];
  assign register_v0 = regs[2];

endmodule

// File: src/mips_decoder.sv
`timescale 1ns/100ps

module mips_decoder (
  input  mips_pkg::instr_u instr,
  output mips_pkg::ctrl_t  ctrl
);

  always_comb begin
    ctrl        = '0;  // unknown encodings become a nop
    ctrl.alu_op = mips_pkg::ALU_ADD;
    case (instr.i.opcode)
      6'h00: begin  // special, decode on funct
        case (instr.r.funct)
          6'h21: ctrl.reg_write = 1'b1;  // addu
          6'h23: begin  // subu
            ctrl.alu_op    = mips_pkg::ALU_SUB;
            ctrl.reg_write = 1'b1;
          end
          6'h24: begin  // and
            ctrl.alu_op    = mips_pkg::ALU_AND;
            ctrl.reg_write = 1'b1;
          end
          6'h25: begin  // or
            ctrl.alu_op    = mips_pkg::ALU_OR;
            ctrl.reg_write = 1'b1;
          end
          6'h2A: begin  // slt
            ctrl.alu_op    = mips_pkg::ALU_SLT;
            ctrl.reg_write = 1'b1;
          end
          6'h08: ctrl.is_jr = 1'b1;
          default: ;
        endcase
      end
      6'h02: ctrl.is_jump = 1'b1;  // j
      6'h04: ctrl.is_beq  = 1'b1;
      6'h05: ctrl.is_bne  = 1'b1;
      6'h09: begin  // addiu
        ctrl.use_imm    = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.dest_is_rt = 1'b1;
      end
      6'h0D: begin  // ori
        ctrl.alu_op     = mips_pkg::ALU_OR;
        ctrl.use_imm    = 1'b1;
        ctrl.zero_ext   = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.dest_is_rt = 1'b1;
      end
      6'h0F: begin  // lui, added to a zero operand
        ctrl.use_imm    = 1'b1;
        ctrl.upper_imm  = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.dest_is_rt = 1'b1;
      end
      6'h23: begin  // lw
        ctrl.use_imm    = 1'b1;
        ctrl.is_load    = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.dest_is_rt = 1'b1;
      end
      6'h2B: begin  // sw
        ctrl.use_imm  = 1'b1;
        ctrl.is_store = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: src/mips_bus_unit.sv
`timescale 1ns/100ps
`include "mips_config.svh"

module mips_bus_unit (
  input  logic                    clk,
  input  logic                    reset,
  input  mips_pkg::bus_req_t      fetch_req,
  input  mips_pkg::bus_req_t      data_req,
  output logic [`MIPS_XLEN-1:0]   address,
  output logic [`MIPS_XLEN-1:0]   writedata,
  output logic                    read,
  output logic                    write,
  output logic [`MIPS_XLEN/8-1:0] byteenable,
  input  logic                    waitrequest,
  input  logic [`MIPS_XLEN-1:0]   readdata,
  output logic                    bus_done,
  output mips_pkg::instr_u        instr,
  output logic [`MIPS_XLEN-1:0]   load_data
);

  mips_pkg::bus_req_t grant;   // winning request
  logic               data_sel;

  // fixed priority, the data side only asks during MEM
  assign data_sel = data_req.read || data_req.write;
  assign grant    = data_sel ? data_req : fetch_req;

  assign address    = grant.addr;
  assign writedata  = grant.wdata;
  assign read       = grant.read;
  assign write      = grant.write;
  assign byteenable = '1;  // word accesses only

  // transfer completes in the first cycle without waitrequest
  assign bus_done = (grant.read || grant.write) && !waitrequest;

  // instruction register, cleared to a nop word
  always_ff @(posedge clk) begin
    if (reset)
      instr <= '0;
    else if (bus_done && grant.read && !data_sel)
      instr <= readdata;
  end

  // load data register
  always_ff @(posedge clk) begin
    if (bus_done && grant.read && data_sel)
      load_data <= readdata;
  end

endmodule

// File: src/mips_sequencer.sv
`timescale 1ns/100ps
`include "mips_config.svh"

module mips_sequencer (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`MIPS_XLEN-1:0] pc,
  input  mips_pkg::ctrl_t       ctrl,
  input  logic                  bus_done,
  output mips_pkg::cpu_state_t  state,
  output logic                  active,
  output mips_pkg::bus_req_t    fetch_req,
  output logic                  mem_phase
);

  logic halt_hit;   // fetch would read the halt address

  assign halt_hit  = (state == mips_pkg::FETCH) && (pc == `MIPS_HALT_ADDR);
  assign mem_phase = (state == mips_pkg::MEM);

  // instruction fetch request, pc with read set
  always_comb begin
    fetch_req.addr  = pc;
    fetch_req.wdata = '0;
    fetch_req.read  = (state == mips_pkg::FETCH) && !halt_hit;  // no access at halt
    fetch_req.write = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= mips_pkg::HALTED;  // halted with active set = start slot
      active <= 1'b1;
    end else begin
      case (state)
        mips_pkg::FETCH: begin
          if (halt_hit) begin
            state  <= mips_pkg::HALTED;
            active <= 1'b0;  // sticky until reset
          end else if (bus_done) begin
            state <= mips_pkg::DECODE;
          end
        end
        mips_pkg::DECODE: begin
          // ctrl is valid here, instr was captured at the end of fetch
          if (ctrl.is_load || ctrl.is_store)
            state <= mips_pkg::MEM;
          else
            state <= mips_pkg::EXEC;
        end
        mips_pkg::MEM: begin
          if (bus_done)
            state <= mips_pkg::EXEC;  // load data lands this edge
        end
        mips_pkg::EXEC: state <= mips_pkg::FETCH;  // pc and rf update here
        mips_pkg::HALTED: begin
          if (active)
            state <= mips_pkg::FETCH;  // leaving reset
        end
        default: state <= mips_pkg::HALTED;
      endcase
    end
  end

endmodule

// File: src/mips_pkg.sv
`include "mips_config.svh"

package mips_pkg;

  // instruction phases, one instruction at a time
  typedef enum logic [2:0] {
    FETCH  = 3'd0,
    DECODE = 3'd1,
    MEM    = 3'd2,   // lw/sw only
    EXEC   = 3'd3,
    HALTED = 3'd4    // also the start slot right after reset
  } cpu_state_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } alu_op_t;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fmt_t;

  // same word, register or immediate layout
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_u;

  typedef struct packed {
    alu_op_t alu_op;
    logic    use_imm;     // operand b from the immediate
    logic    zero_ext;    // ori style immediate
    logic    upper_imm;   // lui, imm placed in the high half
    logic    is_load;
    logic    is_store;
    logic    reg_write;
    logic    dest_is_rt;  // i-type writes rt, r-type writes rd
    logic    is_beq;
    logic    is_bne;
    logic    is_jump;
    logic    is_jr;
  } ctrl_t;

  typedef struct packed {
    logic [`MIPS_XLEN-1:0] addr;
    logic [`MIPS_XLEN-1:0] wdata;
    logic                  read;
    logic                  write;
  } bus_req_t;

  typedef struct packed {
    logic                  we;
    logic [4:0]            idx;
    logic [`MIPS_XLEN-1:0] data;
  } wb_t;

endpackage

// File: src/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// boot address, the kseg1 rom base
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// jumping here ends the program
`define MIPS_HALT_ADDR 32'h0000_0000

`define MIPS_NUM_REGS 32   // architectural gprs

// data and address path width
`define MIPS_XLEN 32

`endif
